/* logic/trace_buf_pkg.sv */
package trace_buf_pkg;

    //////////////////////////////
    // Buffer geometry
    //////////////////////////////

    localparam int unsigned TRACE_WORD_W      = 32;
    localparam int unsigned TRACE_DEPTH       = 64;
    localparam int unsigned TRACE_ENTRY_WORDS = 4;
    localparam int unsigned TRACE_PTR_W       = $clog2(TRACE_DEPTH);
    localparam int unsigned TRACE_WORD_SEL_W  = $clog2(TRACE_ENTRY_WORDS);
    // Entry index on top, word select in the low bits
    localparam int unsigned TRACE_WORD_PTR_W  = TRACE_PTR_W + TRACE_WORD_SEL_W;
    localparam int unsigned TRACE_BUF_WORDS   = TRACE_DEPTH * TRACE_ENTRY_WORDS;
    localparam int unsigned DMI_ADDR_W        = 7;
    localparam int unsigned ECAUSE_W          = 5;

    // Word slots inside one entry
    localparam int unsigned WORD_STATUS  = 0;
    localparam int unsigned WORD_INSN    = 1;
    localparam int unsigned WORD_ADDRESS = 2;
    localparam int unsigned WORD_TVAL    = 3;

    // Status word fields
    localparam int unsigned STATUS_EXC_BIT    = 0;
    localparam int unsigned STATUS_INT_BIT    = 1;
    localparam int unsigned STATUS_ECAUSE_LSB = 2;

    // DMI status register bits
    localparam int unsigned DMI_STATUS_WRAPPED_BIT  = 0;
    localparam int unsigned DMI_STATUS_HAS_DATA_BIT = 1;

    //////////////////////////////
    // DMI register map
    //////////////////////////////

    localparam logic [DMI_ADDR_W-1:0] DMI_TRACE_STATUS = 7'h70;
    localparam logic [DMI_ADDR_W-1:0] DMI_TRACE_CONFIG = 7'h71;
    localparam logic [DMI_ADDR_W-1:0] DMI_TRACE_DATA   = 7'h72;
    localparam logic [DMI_ADDR_W-1:0] DMI_TRACE_WR_PTR = 7'h73;
    localparam logic [DMI_ADDR_W-1:0] DMI_TRACE_RD_PTR = 7'h74;

    // One stored entry, word 0 in the low bits
    typedef logic [TRACE_ENTRY_WORDS-1:0][TRACE_WORD_W-1:0] trace_entry_t;

endpackage

/* logic/trace_capture.sv */
`timescale 1ns/1ps

module trace_capture (
    input  logic                                   clk,
    input  logic                                   rst_i,

    // Retired instruction packet from the core
    input  logic [trace_buf_pkg::TRACE_WORD_W-1:0] trace_insn_i,
    input  logic [trace_buf_pkg::TRACE_WORD_W-1:0] trace_address_i,
    input  logic [trace_buf_pkg::TRACE_WORD_W-1:0] trace_tval_i,
    input  logic                                   trace_valid_i,
    input  logic                                   trace_exception_i,
    input  logic [trace_buf_pkg::ECAUSE_W-1:0]     trace_ecause_i,
    input  logic                                   trace_interrupt_i,

    // Packed entry towards the store
    output logic                                   entry_valid_o,
    output trace_buf_pkg::trace_entry_t            entry_o
);

    import trace_buf_pkg::*;

    trace_entry_t entry_d;

    //////////////////////////////
    // Packing
    //////////////////////////////

    always_comb begin
        entry_d = '0;
        // Status word, upper bits stay zero
        entry_d[WORD_STATUS][STATUS_EXC_BIT]                   = trace_exception_i;
        entry_d[WORD_STATUS][STATUS_INT_BIT]                   = trace_interrupt_i;
        entry_d[WORD_STATUS][STATUS_ECAUSE_LSB +: ECAUSE_W]    = trace_ecause_i;
        entry_d[WORD_INSN]                                     = trace_insn_i;
        entry_d[WORD_ADDRESS]                                  = trace_address_i;
        entry_d[WORD_TVAL]                                     = trace_tval_i;
    end

    //////////////////////////////
    // Capture registers
    //////////////////////////////

    // One-cycle strobe per captured packet
    always_ff @(posedge clk) begin
        if (rst_i) begin
            entry_valid_o <= 1'b0;
        end else begin
            entry_valid_o <= trace_valid_i;
        end
    end

    // Payload holds between strobes
    always_ff @(posedge clk) begin
        if (trace_valid_i) begin
            entry_o <= entry_d;
        end
    end

endmodule

/* logic/trace_store.sv */
`timescale 1ns/1ps

module trace_store (
    input  logic                                       clk,
    input  logic                                       rst_i,

    // Write side
    input  logic                                       entry_valid_i,
    input  trace_buf_pkg::trace_entry_t                entry_i,

    // Word read port
    input  logic [trace_buf_pkg::TRACE_WORD_PTR_W-1:0] rd_ptr_i,
    output logic [trace_buf_pkg::TRACE_WORD_W-1:0]     rd_word_o,

    // Fill state
    output logic [trace_buf_pkg::TRACE_PTR_W-1:0]      wr_ptr_o,
    output logic                                       wrapped_o,
    output logic                                       has_data_o
);

    import trace_buf_pkg::*;

    trace_entry_t                mem [TRACE_DEPTH];
    logic [TRACE_PTR_W-1:0]      rd_entry;
    logic [TRACE_WORD_SEL_W-1:0] rd_sel;
    logic                        last_slot;

    assign last_slot = (wr_ptr_o == TRACE_PTR_W'(TRACE_DEPTH - 1));

    //////////////////////////////
    // Circular write
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (entry_valid_i) begin
            mem[wr_ptr_o] <= entry_i;
        end
    end

    // Pointer wraps naturally at TRACE_DEPTH; flags are sticky
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_o   <= '0;
            wrapped_o  <= 1'b0;
            has_data_o <= 1'b0;
        end else if (entry_valid_i) begin
            wr_ptr_o   <= wr_ptr_o + TRACE_PTR_W'(1);
            has_data_o <= 1'b1;
            if (last_slot) begin
                wrapped_o <= 1'b1;
            end
        end
    end

    // Read select, entry from the top bits and word from the bottom
    assign rd_entry  = rd_ptr_i[TRACE_WORD_PTR_W-1:TRACE_WORD_SEL_W];
    assign rd_sel    = rd_ptr_i[TRACE_WORD_SEL_W-1:0];
    assign rd_word_o = mem[rd_entry][rd_sel];

endmodule

/* logic/trace_dmi_regs.sv */
`timescale 1ns/1ps

module trace_dmi_regs (
    input  logic                                       clk,
    input  logic                                       rst_i,

    // DMI access
    input  logic                                       dmi_en_i,
    input  logic                                       dmi_wr_en_i,
    input  logic [trace_buf_pkg::DMI_ADDR_W-1:0]       dmi_addr_i,
    input  logic [trace_buf_pkg::TRACE_WORD_W-1:0]     dmi_wdata_i,
    output logic [trace_buf_pkg::TRACE_WORD_W-1:0]     dmi_rdata_o,

    // Debug unlock level
    input  logic                                       debug_en_i,

    // Store state and read port
    input  logic [trace_buf_pkg::TRACE_PTR_W-1:0]      wr_ptr_i,
    input  logic                                       wrapped_i,
    input  logic                                       has_data_i,
    input  logic [trace_buf_pkg::TRACE_WORD_W-1:0]     rd_word_i,
    output logic [trace_buf_pkg::TRACE_WORD_PTR_W-1:0] rd_ptr_o
);

    import trace_buf_pkg::*;

    logic                    rd_strobe;
    logic                    rd_ptr_wr;
    logic [TRACE_WORD_W-1:0] status_word;
    logic [TRACE_WORD_W-1:0] rdata_d;

    assign rd_strobe = dmi_en_i & ~dmi_wr_en_i;
    assign rd_ptr_wr = dmi_en_i & dmi_wr_en_i & (dmi_addr_i == DMI_TRACE_RD_PTR);

    //////////////////////////////
    // Read pointer register
    //////////////////////////////

    // Only RD_PTR is writable, other write addresses are dropped
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_ptr_o <= '0;
        end else if (rd_ptr_wr) begin
            rd_ptr_o <= dmi_wdata_i[TRACE_WORD_PTR_W-1:0];
        end
    end

    //////////////////////////////
    // Read decode
    //////////////////////////////

    always_comb begin
        status_word                         = '0;
        status_word[DMI_STATUS_WRAPPED_BIT]  = wrapped_i;
        status_word[DMI_STATUS_HAS_DATA_BIT] = has_data_i;
    end

    always_comb begin
        unique case (dmi_addr_i)
            DMI_TRACE_STATUS: rdata_d = status_word;
            DMI_TRACE_CONFIG: rdata_d = TRACE_WORD_W'(TRACE_BUF_WORDS);
            // Trace contents hidden while debug is locked
            DMI_TRACE_DATA:   rdata_d = debug_en_i ? rd_word_i : '0;
            DMI_TRACE_WR_PTR: rdata_d = TRACE_WORD_W'(wr_ptr_i);
            DMI_TRACE_RD_PTR: rdata_d = TRACE_WORD_W'(rd_ptr_o);
            default:          rdata_d = '0;
        endcase
    end

    // Read data held until the next read strobe
    always_ff @(posedge clk) begin
        if (rst_i) begin
            dmi_rdata_o <= '0;
        end else if (rd_strobe) begin
            dmi_rdata_o <= rdata_d;
        end
    end

endmodule

/* logic/mcu_trace_buffer.sv */
`timescale 1ns/1ps

module mcu_trace_buffer (
    input  logic                                   clk,
    input  logic                                   rst_i,

    // Core trace
    input  logic [trace_buf_pkg::TRACE_WORD_W-1:0] trace_insn_i,
    input  logic [trace_buf_pkg::TRACE_WORD_W-1:0] trace_address_i,
    input  logic [trace_buf_pkg::TRACE_WORD_W-1:0] trace_tval_i,
    input  logic                                   trace_valid_i,
    input  logic                                   trace_exception_i,
    input  logic [trace_buf_pkg::ECAUSE_W-1:0]     trace_ecause_i,
    input  logic                                   trace_interrupt_i,

    // Debugger DMI
    input  logic                                   dmi_en_i,
    input  logic                                   dmi_wr_en_i,
    input  logic [trace_buf_pkg::DMI_ADDR_W-1:0]   dmi_addr_i,
    input  logic [trace_buf_pkg::TRACE_WORD_W-1:0] dmi_wdata_i,
    output logic [trace_buf_pkg::TRACE_WORD_W-1:0] dmi_rdata_o,
    input  logic                                   debug_en_i
);

    import trace_buf_pkg::*;

    logic                        entry_valid;
    trace_entry_t                entry;
    logic [TRACE_PTR_W-1:0]      wr_ptr;
    logic                        wrapped;
    logic                        has_data;
    logic [TRACE_WORD_PTR_W-1:0] rd_ptr;
    logic [TRACE_WORD_W-1:0]     rd_word;

    trace_capture u_capture (
        .clk               (clk),
        .rst_i             (rst_i),
        .trace_insn_i      (trace_insn_i),
        .trace_address_i   (trace_address_i),
        .trace_tval_i      (trace_tval_i),
        .trace_valid_i     (trace_valid_i),
        .trace_exception_i (trace_exception_i),
        .trace_ecause_i    (trace_ecause_i),
        .trace_interrupt_i (trace_interrupt_i),
        .entry_valid_o     (entry_valid),
        .entry_o           (entry)
    );

    trace_store u_store (
        .clk           (clk),
        .rst_i         (rst_i),
        .entry_valid_i (entry_valid),
        .entry_i       (entry),
        .rd_ptr_i      (rd_ptr),
        .rd_word_o     (rd_word),
        .wr_ptr_o      (wr_ptr),
        .wrapped_o     (wrapped),
        .has_data_o    (has_data)
    );

    trace_dmi_regs u_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .dmi_en_i    (dmi_en_i),
        .dmi_wr_en_i (dmi_wr_en_i),
        .dmi_addr_i  (dmi_addr_i),
        .dmi_wdata_i (dmi_wdata_i),
        .dmi_rdata_o (dmi_rdata_o),
        .debug_en_i  (debug_en_i),
        .wr_ptr_i    (wr_ptr),
        .wrapped_i   (wrapped),
        .has_data_i  (has_data),
        .rd_word_i   (rd_word),
        .rd_ptr_o    (rd_ptr)
    );

endmodule

/* dv/mcu_trace_buffer_sva.sv */
`timescale 1ns/1ps

module mcu_trace_buffer_sva (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   dmi_en_i,
    input  logic                                   dmi_wr_en_i,
    input  logic [trace_buf_pkg::DMI_ADDR_W-1:0]   dmi_addr_i,
    input  logic [trace_buf_pkg::TRACE_WORD_W-1:0] dmi_rdata_o,
    input  logic                                   debug_en_i
);

    import trace_buf_pkg::*;

    int unsigned fail_count = 0;
    logic        rd_strobe;

    assign rd_strobe = dmi_en_i && !dmi_wr_en_i;

    // Read data only moves on a read strobe
    rdata_hold: assert property (@(posedge clk) disable iff (rst_i)
        !$past(rd_strobe) |-> $stable(dmi_rdata_o))
    else begin
        fail_count++;
        $error("read data changed without a read strobe");
    end

    // Buffer size is 64 entries of 4 words
    config_value: assert property (@(posedge clk) disable iff (rst_i)
        rd_strobe && (dmi_addr_i == DMI_TRACE_CONFIG) |=> dmi_rdata_o == 32'd256)
    else begin
        fail_count++;
        $error("config register did not read as 256 words");
    end

    data_locked: assert property (@(posedge clk) disable iff (rst_i)
        rd_strobe && (dmi_addr_i == DMI_TRACE_DATA) && !debug_en_i |=> dmi_rdata_o == '0)
    else begin
        fail_count++;
        $error("trace data was visible while debug was locked");
    end

    rdata_reset: assert property (@(posedge clk) rst_i |=> dmi_rdata_o == '0)
    else begin
        fail_count++;
        $error("read data was not cleared by reset");
    end

endmodule

/* dv/tb_mcu_trace_buffer.sv */
`timescale 1ns/1ps

module tb_mcu_trace_buffer;

    import trace_buf_pkg::*;

    localparam int unsigned RESET_CYCLES = 16;
    localparam longint      RUN_LIMIT_NS = 2_000_000;

    logic clk, rst_i, debug_en_i;
    logic [31:0] trace_insn_i, trace_address_i, trace_tval_i;
    logic trace_valid_i, trace_exception_i, trace_interrupt_i;
    logic [4:0] trace_ecause_i;
    logic dmi_en_i, dmi_wr_en_i;
    logic [6:0] dmi_addr_i;
    logic [31:0] dmi_wdata_i, dmi_rdata_o;

    logic [31:0] lfsr = 32'hd529_92d0;
    // Expected buffer contents indexed by slot * 4 + word
    logic [31:0] model_mem [0:255];
    int unsigned pkt_count = 0;
    int unsigned checks = 0;
    int unsigned errors = 0;

    mcu_trace_buffer DUT (.*);

    bind mcu_trace_buffer mcu_trace_buffer_sva u_sva (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("mismatch %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
        @(posedge clk);
        #5;
        dmi_en_i = 1'b1;
        dmi_wr_en_i = 1'b1;
        dmi_addr_i = addr;
        dmi_wdata_i = data;
        @(posedge clk);
        #5;
        dmi_en_i = 1'b0;
        dmi_wr_en_i = 1'b0;
    endtask

    // Strobe and take the data one edge later
    task automatic expect_reg(input string name, input logic [6:0] addr,
                              input logic [31:0] exp);
        @(posedge clk);
        #5;
        dmi_en_i = 1'b1;
        dmi_addr_i = addr;
        @(posedge clk);
        #5;
        dmi_en_i = 1'b0;
        check_value(name, exp, dmi_rdata_o);
    endtask

    task automatic set_debug(input logic level);
        @(posedge clk);
        #5;
        debug_en_i = level;
    endtask

    task automatic send_packets(input int n, input bit back_to_back);
        logic [31:0] bits;
        int unsigned base;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #5;
            trace_insn_i = next_bits(32);
            trace_address_i = next_bits(32);
            trace_tval_i = next_bits(32);
            bits = next_bits(7);
            trace_exception_i = bits[0];
            trace_interrupt_i = bits[1];
            trace_ecause_i = bits[6:2];
            trace_valid_i = 1'b1;
            // Oldest slot is overwritten once full
            base = (pkt_count % 64) * 4;
            model_mem[base] = {25'd0, bits[6:2], bits[1], bits[0]};
            model_mem[base + 1] = trace_insn_i;
            model_mem[base + 2] = trace_address_i;
            model_mem[base + 3] = trace_tval_i;
            pkt_count++;
            if (!back_to_back) begin
                @(posedge clk);
                #5;
                trace_valid_i = 1'b0;
            end
        end
        @(posedge clk);
        #5;
        trace_valid_i = 1'b0;
    endtask

    task automatic read_entries(input string name, input int unsigned count);
        for (int p = 0; p < count * 4; p++) begin
            write_reg(DMI_TRACE_RD_PTR, p);
            expect_reg(name, DMI_TRACE_DATA, model_mem[p]);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        rst_i = 1'b1;
        debug_en_i = 1'b0;
        {trace_insn_i, trace_address_i, trace_tval_i} = '0;
        {trace_valid_i, trace_exception_i, trace_interrupt_i, trace_ecause_i} = '0;
        {dmi_en_i, dmi_wr_en_i, dmi_addr_i, dmi_wdata_i} = '0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        #5;
        rst_i = 1'b0;

        // DATA is gated while debug is still locked
        expect_reg("reset_status", DMI_TRACE_STATUS, 32'd0);
        expect_reg("reset_wr_ptr", DMI_TRACE_WR_PTR, 32'd0);
        expect_reg("reset_rd_ptr", DMI_TRACE_RD_PTR, 32'd0);
        expect_reg("reset_data", DMI_TRACE_DATA, 32'd0);
        expect_reg("reset_config", DMI_TRACE_CONFIG, 32'd256);
        set_debug(1'b1);

        send_packets(10, 1'b0);
        repeat (2) @(posedge clk);
        expect_reg("count_wr_ptr", DMI_TRACE_WR_PTR, 32'd10);
        expect_reg("count_status", DMI_TRACE_STATUS, 32'd2);
        read_entries("readback_data", 10);
        expect_reg("readback_rd_ptr", DMI_TRACE_RD_PTR, 32'd39);

        // Writes to other registers leave the read pointer alone
        write_reg(DMI_TRACE_STATUS, 32'd5);
        expect_reg("other_write_rd_ptr", DMI_TRACE_RD_PTR, 32'd39);
        expect_reg("unknown_addr", 7'h75, 32'd0);

        // After 70 packets entry 0 holds packet 64
        send_packets(30, 1'b1);
        send_packets(30, 1'b0);
        repeat (2) @(posedge clk);
        expect_reg("wrap_wr_ptr", DMI_TRACE_WR_PTR, 32'd6);
        expect_reg("wrap_status", DMI_TRACE_STATUS, 32'd3);
        read_entries("wrap_data", 64);

        set_debug(1'b0);
        for (int p = 0; p < 8; p++) begin
            write_reg(DMI_TRACE_RD_PTR, p);
            expect_reg("lock_data", DMI_TRACE_DATA, 32'd0);
        end
        expect_reg("lock_wr_ptr", DMI_TRACE_WR_PTR, 32'd6);
        expect_reg("lock_status", DMI_TRACE_STATUS, 32'd3);
        set_debug(1'b1);
        read_entries("unlock_data", 2);

        repeat (2) @(posedge clk);
        $display("checks %0d, check errors %0d, assertion failures %0d",
                 checks, errors, DUT.u_sva.fail_count);
        if (errors == 0 && DUT.u_sva.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(RUN_LIMIT_NS);
        $display("run exceeded its time limit before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* project.f */
logic/trace_buf_pkg.sv
logic/trace_capture.sv
logic/trace_store.sv
logic/trace_dmi_regs.sv
logic/mcu_trace_buffer.sv
dv/mcu_trace_buffer_sva.sv
dv/tb_mcu_trace_buffer.sv

/* Bender.yml */
package:
  name: mcu_trace_buffer

sources:
  - logic/trace_buf_pkg.sv
  - logic/trace_capture.sv
  - logic/trace_store.sv
  - logic/trace_dmi_regs.sv
  - logic/mcu_trace_buffer.sv
  - target: simulation
    files:
      - dv/mcu_trace_buffer_sva.sv
      - dv/tb_mcu_trace_buffer.sv
